//--- hdl/u1plus_defines.svh
`ifndef U1PLUS_DEFINES_SVH
`define U1PLUS_DEFINES_SVH

//////////////////////////////////////////////////
// register bus geometry
`define U1_AW 11   // byte address
`define U1_DW 16   // data word

// board identity, bump when the register map changes
`define U1_COMPAT_NUM 8'd3

//////////////////////////////////////////////////
// settings bus addresses (32-bit registers)
`define U1_SR_TIME64     40   // +0 time high, +1 time low
`define U1_SR_REG_TEST32 52

//////////////////////////////////////////////////
// misc slave
`define U1_CGEN_RESET    2'b11     // sync_b high, ref_sel high
`define U1_UNMAPPED_READ 16'hBEEF

// byte offsets inside the misc slave
`define U1_REG_LEDS      7'd0
`define U1_REG_CGEN_CTRL 7'd4
`define U1_REG_CGEN_ST   7'd6
`define U1_REG_TEST      7'd8
`define U1_REG_COMPAT    7'd16

`endif

//--- hdl/u1_bus_pkg.sv
`include "u1plus_defines.svh"

package u1_bus_pkg;

   typedef logic [`U1_DW-1:0] bus_data_t;

   // upper nibble of the byte address
   typedef enum logic [3:0] {
      SLV_MISC        = 4'd0,
      SLV_READBACK    = 4'd7,
      SLV_SETTINGS_LO = 4'd8,   // settings take the 8/9 pair
      SLV_SETTINGS_HI = 4'd9
   } slave_sel_e;

   // one address word, seen by the decoder and by the 16LE slaves
   typedef union packed {
      struct packed {
         slave_sel_e            sel;
         logic [`U1_AW-5:0]     offset;
      } dec;
      struct packed {
         logic [2:0]            pair;    // slave pair, lsb of select dropped
         logic [5:0]            index;   // register or word index
         logic                  half;    // 0 low 16 bits, 1 high 16 bits
         logic                  lsb;     // byte bit, unused on a 16-bit bus
      } set;
   } wb_addr_u;

endpackage

//--- hdl/u1_set_pkg.sv
package u1_set_pkg;

   //////////////////////////////////////////////////
   // settings bus
   //
   // one strobe per 32-bit register write, the
   // address is the register number, not a byte
   // address, so 256 registers fit

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   //////////////////////////////////////////////////
   // timekeeping
   //
   // VITA time as a single free running tick
   // counter, the high word is written first and
   // held until the low word arrives

   typedef logic [63:0] vita_time_t;

endpackage

//--- hdl/wb_slave_decoder.sv
`timescale 1ns/1ps

module wb_slave_decoder
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  u1_bus_pkg::wb_addr_u  wb_adr_i,
   input  logic                  wb_cyc_i,
   input  logic                  wb_stb_i,
   output logic                  wb_ack_o,
   output logic                  wb_err_o,
   output u1_bus_pkg::bus_data_t wb_dat_o,
   output logic                  misc_stb_o,
   output logic                  set_stb_o,
   output logic                  rb_stb_o,
   input  logic                  misc_ack_i,
   input  logic                  set_ack_i,
   input  logic                  rb_ack_i,
   input  u1_bus_pkg::bus_data_t misc_dat_i,
   input  u1_bus_pkg::bus_data_t rb_dat_i
);

   logic req;
   logic hit_misc, hit_rb, hit_set, unmapped;
   logic err_pend;   // error given, waiting for stb to drop

   // slave select, settings match on the pair with the lsb masked
   assign hit_misc = (wb_adr_i.dec.sel == u1_bus_pkg::SLV_MISC);
   assign hit_rb   = (wb_adr_i.dec.sel == u1_bus_pkg::SLV_READBACK);
   assign hit_set  = ({wb_adr_i.set.pair, 1'b0} == 4'(u1_bus_pkg::SLV_SETTINGS_LO));
   assign unmapped = ~(hit_misc | hit_rb | hit_set);

   assign req = wb_cyc_i & wb_stb_i & ~err_pend;

   assign misc_stb_o = req & hit_misc;
   assign set_stb_o  = req & hit_set;
   assign rb_stb_o   = req & hit_rb;
   assign wb_err_o   = req & unmapped;   // same cycle, no ack

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         err_pend <= 1'b0;
      else if (wb_err_o)
         err_pend <= 1'b1;
      else if (~(wb_cyc_i & wb_stb_i))
         err_pend <= 1'b0;
   end

   // return path follows the same select
   always_comb
   begin
      wb_ack_o = 1'b0;
      wb_dat_o = '0;
      if (hit_misc)
      begin
         wb_ack_o = misc_ack_i;
         wb_dat_o = misc_dat_i;
      end
      else if (hit_rb)
      begin
         wb_ack_o = rb_ack_i;
         wb_dat_o = rb_dat_i;
      end
      else if (hit_set)
         wb_ack_o = set_ack_i;   // write only, reads give 0
   end

endmodule

//--- hdl/misc_regs.sv
`timescale 1ns/1ps

`include "u1plus_defines.svh"

module misc_regs
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  logic [6:0]            offset_i,
   input  u1_bus_pkg::bus_data_t dat_i,
   output u1_bus_pkg::bus_data_t dat_o,
   output logic                  ack_o,
   input  logic                  cgen_st_status_i,
   input  logic                  cgen_st_ld_i,
   input  logic                  cgen_st_refmon_i,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   output logic [2:0]            debug_led_o
);

   u1_bus_pkg::bus_data_t reg_leds;
   logic [1:0]            reg_cgen_ctrl;
   u1_bus_pkg::bus_data_t reg_test;

   assign ack_o = stb_i;   // no wait states

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= `U1_CGEN_RESET;
         reg_test      <= '0;
      end
      else if (stb_i & we_i)
      begin
         case (offset_i)
            `U1_REG_LEDS      : reg_leds      <= dat_i;
            `U1_REG_CGEN_CTRL : reg_cgen_ctrl <= dat_i[1:0];
            `U1_REG_TEST      : reg_test      <= dat_i;
            default           : ;   // read only or unused
         endcase
      end
   end

   always_comb
   begin
      case (offset_i)
         `U1_REG_LEDS      : dat_o = reg_leds;
         `U1_REG_CGEN_CTRL : dat_o = {14'd0, reg_cgen_ctrl};
         `U1_REG_CGEN_ST   : dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         `U1_REG_TEST      : dat_o = reg_test;
         `U1_REG_COMPAT    : dat_o = {8'd0, `U1_COMPAT_NUM};
         default           : dat_o = `U1_UNMAPPED_READ;
      endcase
   end

   // leds are wired out of order on the board
   assign {debug_led_o[1], debug_led_o[0], debug_led_o[2]} = reg_leds[2:0];

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl;

endmodule

//--- hdl/settings_bus_16le.sv
`timescale 1ns/1ps

module settings_bus_16le
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  u1_bus_pkg::wb_addr_u  adr_i,
   input  u1_bus_pkg::bus_data_t dat_i,
   output logic                  ack_o,
   output logic                  set_stb_o,
   output u1_set_pkg::set_addr_t set_addr_o,
   output u1_set_pkg::set_data_t set_data_o
);

   u1_bus_pkg::bus_data_t low_half;   // waits for the high write
   logic                  wr_low, wr_high;

   assign ack_o = stb_i;

   // little endian, low half first
   assign wr_low  = stb_i & we_i & ~adr_i.set.half;
   assign wr_high = stb_i & we_i &  adr_i.set.half;

   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
         low_half <= dat_i;
   end

   //////////////////////////////////////////////////
   // the high half completes the 32-bit setting

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;   // one cycle pulse
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_high)
      begin
         set_addr_o <= {2'b00, adr_i.set.index};
         set_data_o <= {dat_i, low_half};
      end
   end

endmodule

//--- hdl/time_64bit.sv
`timescale 1ns/1ps

`include "u1plus_defines.svh"

module time_64bit
(
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  u1_set_pkg::set_addr_t  set_addr_i,
   input  u1_set_pkg::set_data_t  set_data_i,
   input  logic                   pps_i,
   output u1_set_pkg::vita_time_t vita_time_o,
   output u1_set_pkg::vita_time_t vita_time_pps_o
);

   u1_set_pkg::set_data_t time_hi;   // held until the low word
   logic                  wr_hi, wr_lo;

   logic [1:0]            pps_sync;
   logic                  pps_d;
   logic                  pps_rise;

   assign wr_hi = set_stb_i &
                  (set_addr_i == u1_set_pkg::set_addr_t'(`U1_SR_TIME64));
   assign wr_lo = set_stb_i &
                  (set_addr_i == u1_set_pkg::set_addr_t'(`U1_SR_TIME64 + 1));

   always_ff @(posedge wb_clk)
   begin
      if (wr_hi)
         time_hi <= set_data_i;
   end

   // free running tick counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_o <= '0;
      else if (wr_lo)
         vita_time_o <= {time_hi, set_data_i};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   //////////////////////////////////////////////////
   // pps capture

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= 2'b00;
         pps_d    <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};   // async input
         pps_d    <= pps_sync[1];
      end
   end

   assign pps_rise = pps_sync[1] & ~pps_d;

   always_ff @(posedge wb_clk)
   begin
      if (pps_rise)
         vita_time_pps_o <= vita_time_o;
   end

endmodule

//--- hdl/readback_mux_16le.sv
`timescale 1ns/1ps

`include "u1plus_defines.svh"

module readback_mux_16le
(
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   input  logic                   stb_i,
   input  u1_bus_pkg::wb_addr_u   adr_i,
   output logic                   ack_o,
   output u1_bus_pkg::bus_data_t  dat_o,
   input  logic                   set_stb_i,
   input  u1_set_pkg::set_addr_t  set_addr_i,
   input  u1_set_pkg::set_data_t  set_data_i,
   input  u1_set_pkg::vita_time_t vita_time_i,
   input  u1_set_pkg::vita_time_t vita_time_pps_i
);

   u1_set_pkg::set_data_t reg_test32;
   u1_set_pkg::set_data_t word;

   // test setting, only here to check the settings path
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32 <= '0;
      else if (set_stb_i &&
               set_addr_i == u1_set_pkg::set_addr_t'(`U1_SR_REG_TEST32))
         reg_test32 <= set_data_i;
   end

   always_comb
   begin
      case (adr_i.dec.offset[5:2])   // word index
         4'd0    : word = vita_time_i[63:32];
         4'd1    : word = vita_time_i[31:0];
         4'd2    : word = vita_time_pps_i[63:32];
         4'd3    : word = vita_time_pps_i[31:0];
         4'd4    : word = reg_test32;
         default : word = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // registered ack, a single cycle per access

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= stb_i & ~ack_o;
   end

   always_ff @(posedge wb_clk)
   begin
      dat_o <= adr_i.set.half ? word[31:16] : word[15:0];
   end

endmodule

//--- hdl/u1plus_core.sv
`timescale 1ns/1ps

module u1plus_core
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  u1_bus_pkg::wb_addr_u  wb_adr_i,
   input  u1_bus_pkg::bus_data_t wb_dat_i,
   output u1_bus_pkg::bus_data_t wb_dat_o,
   input  logic                  wb_we_i,
   input  logic                  wb_stb_i,
   input  logic                  wb_cyc_i,
   output logic                  wb_ack_o,
   output logic                  wb_err_o,
   input  logic                  pps_i,
   input  logic                  cgen_st_status_i,
   input  logic                  cgen_st_ld_i,
   input  logic                  cgen_st_refmon_i,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   output logic [2:0]            debug_led_o
);

   logic                  misc_stb, set_stb_bus, rb_stb;
   logic                  misc_ack, set_ack, rb_ack;
   u1_bus_pkg::bus_data_t misc_dat, rb_dat;

   logic                  set_stb;
   u1_set_pkg::set_addr_t set_addr;
   u1_set_pkg::set_data_t set_data;

   u1_set_pkg::vita_time_t vita_time, vita_time_pps;

   //////////////////////////////////////////////////
   // bus control
   wb_slave_decoder decoder
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .wb_adr_i(wb_adr_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o), .wb_dat_o(wb_dat_o),
      .misc_stb_o(misc_stb), .set_stb_o(set_stb_bus), .rb_stb_o(rb_stb),
      .misc_ack_i(misc_ack), .set_ack_i(set_ack), .rb_ack_i(rb_ack),
      .misc_dat_i(misc_dat), .rb_dat_i(rb_dat)
   );

   //////////////////////////////////////////////////
   // slave 0, leds and clock generator
   misc_regs misc
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(misc_stb), .we_i(wb_we_i), .offset_i(wb_adr_i.dec.offset),
      .dat_i(wb_dat_i), .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .debug_led_o(debug_led_o)
   );

   //////////////////////////////////////////////////
   // slaves 8 and 9, settings bus bridge
   settings_bus_16le settings
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(set_stb_bus), .we_i(wb_we_i), .adr_i(wb_adr_i), .dat_i(wb_dat_i),
      .ack_o(set_ack),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data)
   );

   time_64bit vita_timer
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   //////////////////////////////////////////////////
   // slave 7, 32-bit readback
   readback_mux_16le readback
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(rb_stb), .adr_i(wb_adr_i), .ack_o(rb_ack), .dat_o(rb_dat),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps)
   );

endmodule

//--- test/u1plus_core_checker.sv
`timescale 1ns/1ps

module u1plus_core_checker
(
   input logic wb_clk,
   input logic wb_rst,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic err_i,
   input logic rb_ack_i
);

   int fail_count = 0;   // read by the testbench at the end of the run

   ack_err_exclusive : assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(ack_i && err_i))
   else
   begin
      $error("ack and error high in the same cycle");
      fail_count++;
   end

   // an ack always answers a live request
   ack_needs_stb : assert property (@(posedge wb_clk) disable iff (wb_rst)
      ack_i |-> (cyc_i && stb_i))
   else
   begin
      $error("ack without cyc and stb");
      fail_count++;
   end

   rb_ack_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      rb_ack_i |=> !rb_ack_i)
   else
   begin
      $error("readback ack longer than one cycle");
      fail_count++;
   end

endmodule

bind u1plus_core u1plus_core_checker checks
(
   .wb_clk(wb_clk), .wb_rst(wb_rst), .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
   .ack_i(wb_ack_o), .err_i(wb_err_o), .rb_ack_i(rb_ack)
);

//--- test/u1plus_core_tb.sv
`timescale 1ns/1ps

module u1plus_core_tb;

   localparam int          ACK_TIMEOUT    = 20;
   localparam logic [10:0] LED_ADR        = 11'h000;
   localparam logic [10:0] TIME_LO_HI_ADR = 11'h4A6;   // high half of setting 41

   logic                  wb_clk, wb_rst;
   u1_bus_pkg::wb_addr_u  wb_adr_i;
   u1_bus_pkg::bus_data_t wb_dat_i, wb_dat_o;
   logic                  wb_we_i, wb_stb_i, wb_cyc_i, wb_ack_o, wb_err_o;
   logic                  pps_i, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i;
   logic                  cgen_sync_b_o, cgen_ref_sel_o;
   logic [2:0]            debug_led_o;

   int              cycle = 0;
   int              load_cycle, pps_cycle;
   logic [8*24-1:0] test_name;

   u1plus_core uut (.*);

   initial wb_clk = 1'b0;
   always #50 wb_clk = ~wb_clk;

   always @(posedge wb_clk) cycle <= cycle + 1;   // edges seen so far

   task automatic fail_run();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_value(input logic [15:0] expected, input logic [15:0] actual);
      assert (actual === expected)
      else
      begin
         $display("ERROR %0s expected %h actual %h", test_name, expected, actual);
         fail_run();
      end
   endtask

   task automatic expect_fields(input int got, input int want);
      assert (got == want)
      else
      begin
         $display("malformed line in the trace file in test %0s", test_name);
         fail_run();
      end
   endtask

   //////////////////////////////////////////////////
   // one bus cycle held until ack or error

   task automatic bus_access(input logic we, input logic [10:0] adr, input logic [15:0] dat,
                             output logic [15:0] rdat, output logic ack, output logic err);
      int waited;
      @(posedge wb_clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      if (we && adr == TIME_LO_HI_ADR)
         load_cycle = cycle;   // time loads two edges later
      waited = 0;
      do
      begin
         @(posedge wb_clk);
         waited++;
      end
      while (!(wb_ack_o || wb_err_o) && waited < ACK_TIMEOUT);
      if (!(wb_ack_o || wb_err_o))
      begin
         $display("no ack or error from the DUT at address %h in test %0s", adr, test_name);
         fail_run();
      end
      rdat = wb_dat_o;
      ack  = wb_ack_o;
      err  = wb_err_o;
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic plain_access(input logic we, input logic [10:0] adr, input logic [15:0] dat,
                               output logic [15:0] rdat);
      logic ack, err;
      bus_access(we, adr, dat, rdat, ack, err);
      assert (!err)
      else
      begin
         $display("unexpected bus error at address %h in test %0s", adr, test_name);
         fail_run();
      end
   endtask

   initial
   begin
      int          fd, n, kind;
      logic [7:0]  tok;
      logic [10:0] adr;
      logic [15:0] dat, rdat, hi;
      logic [31:0] base, value, lo_bound, hi_bound;
      logic [2:0]  bits;
      logic        ack, err;
      logic [8*120-1:0] line;
      wb_rst <= 1'b1;
      {wb_cyc_i, wb_stb_i, wb_we_i, pps_i} <= 4'b0000;
      wb_adr_i <= '0;
      wb_dat_i <= '0;
      {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} <= 3'b000;
      test_name = "reset";
      repeat (5) @(posedge wb_clk);
      wb_rst <= 1'b0;
      @(negedge wb_clk);
      check_value(16'h0000, {13'd0, debug_led_o});
      assert (cgen_sync_b_o && cgen_ref_sel_o)
      else
      begin
         $display("clock generator control pins not high after reset");
         fail_run();
      end
      fd = $fopen("test/u1plus_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the trace file test/u1plus_trace.txt");
         fail_run();
      end
      while ($fscanf(fd, "%s", tok) == 1)
      begin
         case (tok)
            "#" : n = $fgets(line, fd);   // comment line
            "T" :
            begin
               n = $fscanf(fd, "%s", test_name);
               expect_fields(n, 1);
               $display("test %0s", test_name);
            end
            "W" :
            begin
               n = $fscanf(fd, "%h %h", adr, dat);
               expect_fields(n, 2);
               plain_access(1'b1, adr, dat, rdat);
               if (adr == LED_ADR)
               begin
                  @(negedge wb_clk);
                  check_value({13'd0, dat[0], dat[2], dat[1]}, {13'd0, debug_led_o});
               end
            end
            "R" :
            begin
               n = $fscanf(fd, "%h %h", adr, dat);
               expect_fields(n, 2);
               plain_access(1'b0, adr, 16'h0000, rdat);
               check_value(dat, rdat);
            end
            "V" :
            begin
               n = $fscanf(fd, "%h %h %d", adr, base, kind);
               expect_fields(n, 3);
               plain_access(1'b0, adr, 16'h0000, rdat);
               plain_access(1'b0, adr + 11'd2, 16'h0000, hi);
               value = {hi, rdat};
               if (kind == 0)
               begin
                  lo_bound = base;   // live time
                  hi_bound = base + 32'(cycle - load_cycle);
               end
               else
               begin
                  lo_bound = base + 32'(pps_cycle - load_cycle);
                  hi_bound = lo_bound + 32'd3;
               end
               assert (value >= lo_bound && value <= hi_bound)
               else
               begin
                  $display("ERROR %0s expected %h to %h actual %h",
                           test_name, lo_bound, hi_bound, value);
                  fail_run();
               end
            end
            "P" :
            begin
               @(posedge wb_clk);
               pps_i <= 1'b1;
               pps_cycle = cycle;
               repeat (4) @(posedge wb_clk);
               pps_i <= 1'b0;
            end
            "E" :
            begin
               n = $fscanf(fd, "%h", adr);
               expect_fields(n, 1);
               bus_access(1'b0, adr, 16'h0000, rdat, ack, err);
               check_value(16'h0001, {15'd0, err});
               check_value(16'h0000, {15'd0, ack});
               check_value(16'h0000, rdat);
            end
            "S" :
            begin
               n = $fscanf(fd, "%h", bits);
               expect_fields(n, 1);
               @(posedge wb_clk);
               {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} <= bits;
            end
            default :
            begin
               $display("unknown command in the trace file");
               fail_run();
            end
         endcase
      end
      $fclose(fd);
      @(posedge wb_clk);
      if (uut.checks.fail_count == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
         fail_run();
   end

endmodule

//--- u1plus_core.f
+incdir+hdl
hdl/u1_bus_pkg.sv
hdl/u1_set_pkg.sv
hdl/wb_slave_decoder.sv
hdl/misc_regs.sv
hdl/settings_bus_16le.sv
hdl/time_64bit.sv
hdl/readback_mux_16le.sv
hdl/u1plus_core.sv
test/u1plus_core_checker.sv
test/u1plus_core_tb.sv

//--- Makefile
# Verilator build and run of the u1plus control core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f u1plus_core.f --top-module u1plus_core_tb -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/u1plus_trace.txt
# T name | W addr data | R addr expected | V addr base kind (0 live, 1 pps)
# P pps pulse | E addr expects error | S status bits {status, ld, refmon}; all hex
T reset_values
R 000 0000
R 004 0003
R 008 0000
T misc_regs
W 000 0005
W 000 0003
R 000 0003
W 004 0001
R 004 0001
S 5
R 006 0005
S 2
R 006 0002
W 008 A5C3
R 008 A5C3
R 010 0003
R 00C BEEF
T test_setting
W 4D0 1234
W 4D2 CAFE
R 390 1234
R 392 CAFE
T time_load
W 4A0 0002
W 4A2 0000
W 4A4 1000
W 4A6 0000
R 380 0002
R 382 0000
V 384 00001000 0
T pps_capture
P
V 38C 00001000 1
R 388 0002
R 38A 0000
T unmapped
E 080
E 780
R 010 0003
